//--- design/fb_pkg.sv
// ##########################################################
// framebuffer geometry, display timing and fixed palette
// the scaler hardwires FB_SCALE 2; the palette has no write port
// ##########################################################

package fb_pkg;
    localparam int CORDW = 8;   // signed coordinate bits
    localparam int CIDXW = 4;   // colour index bits
    localparam int CHANW = 4;   // bits per colour channel
    localparam int COLRW = 3 * CHANW;

    // framebuffer
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 16;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 512
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);
    localparam int FB_XW     = $clog2(FB_WIDTH);      // column bits of an address
    localparam int FB_YW     = $clog2(FB_HEIGHT);     // row bits
    localparam int FB_SCALE  = 2;
    localparam int FB_OFFX   = 8;   // painted area origin on screen
    localparam int FB_OFFY   = 4;
    localparam int PAINT_W   = FB_WIDTH * FB_SCALE;   // 64 screen pixels
    localparam int PAINT_H   = FB_HEIGHT * FB_SCALE;  // 32 screen lines

    // display timing, no sync pulses
    localparam int H_ACTIVE = 80;
    localparam int H_TOTAL  = 100;
    localparam int V_ACTIVE = 40;
    localparam int V_TOTAL  = 48;

    localparam int ADDR_LAT = 3;  // bitmap_addr pipeline depth

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0]        cidx_t;
    typedef logic [COLRW-1:0]        colr_t;
    typedef logic [FB_ADDRW-1:0]     fb_addr_t;

    // entry 0 is the cleared background, kept off black
    localparam colr_t PALETTE [2**CIDXW] = '{
        12'h112, 12'hF00, 12'h0F0, 12'h00F,
        12'hFF0, 12'h0FF, 12'hF0F, 12'hFFF,
        12'h888, 12'hF80, 12'h8F0, 12'h08F,
        12'hF08, 12'h80F, 12'h0F8, 12'h444
    };

    typedef enum logic [2:0] {IDLE, INIT, CLEAR, DRAW, DONE} fb_state_t;
endpackage

//--- design/display_timing.sv
// ##########################################################
// 80x40 active inside a 100x48 frame, no sync outputs
// de, line and frame decode the registered counters
// ##########################################################

`timescale 1ns/1ns

module display_timing import fb_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    output coord_t sx,
    output coord_t sy,
    output logic   de,
    output logic   line,
    output logic   frame
);
    logic h_last;  // last pixel of a line
    logic v_last;  // last line of a frame

    always_comb begin
        h_last = (sx == H_TOTAL - 1);
        v_last = (sy == V_TOTAL - 1);
    end

    // scan counters
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end else if (h_last) begin
            sx <= '0;
            sy <= v_last ? '0 : sy + coord_t'(1);  // wrap at frame end
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // decodes line up with sx/sy on the same cycle
    always_comb begin
        de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        line  = (sx == 0);               // one cycle per line
        frame = (sx == 0) && (sy == 0);  // one cycle per frame
    end
endmodule

//--- design/render_square.sv
// ##########################################################
// filled square, one pixel per cycle, row by row
// shape_size must be 1 to 16; shape ports sampled on req rise
// ##########################################################

`timescale 1ns/1ns

module render_square import fb_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    input  logic   draw_req,
    input  coord_t shape_x,
    input  coord_t shape_y,
    input  coord_t shape_size,
    input  cidx_t  shape_cidx,
    output coord_t drx,
    output coord_t dry,
    output cidx_t  draw_cidx,
    output logic   drawing,
    output logic   draw_ack
);
    typedef enum logic [1:0] {R_IDLE, R_DRAW, R_LAST, R_ACK} rsq_state_t;

    rsq_state_t state;
    logic       req_q;      // previous draw_req, for edge detect
    logic       start;
    logic       last_x, last_y;
    coord_t     x0, y0, size;
    cidx_t      cidx_l;
    coord_t     cx, cy;     // offsets inside the square

    always_comb begin
        start  = (state == R_IDLE) && draw_req && !req_q;
        last_x = (cx == size - coord_t'(1));
        last_y = (cy == size - coord_t'(1));
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state    <= R_IDLE;
            req_q    <= 1'b0;
            drawing  <= 1'b0;
            draw_ack <= 1'b0;
        end else begin
            req_q <= draw_req;
            case (state)
                R_IDLE: if (start) state <= R_DRAW;
                R_DRAW: begin
                    drawing <= 1'b1;
                    if (last_x && last_y) state <= R_LAST;
                end
                R_LAST: begin  // last pixel is on the outputs now
                    drawing  <= 1'b0;
                    draw_ack <= 1'b1;
                    state    <= R_ACK;
                end
                R_ACK: begin
                    if (!draw_req) begin  // four-phase return to zero
                        draw_ack <= 1'b0;
                        state    <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (start) begin
            x0     <= shape_x;
            y0     <= shape_y;
            size   <= shape_size;
            cidx_l <= shape_cidx;
            cx     <= '0;
            cy     <= '0;
        end else if (state == R_DRAW) begin
            drx       <= x0 + cx;
            dry       <= y0 + cy;
            draw_cidx <= cidx_l;
            cx        <= last_x ? '0 : cx + coord_t'(1);
            if (last_x) cy <= cy + coord_t'(1);  // next row
        end
    end
endmodule

//--- design/bitmap_addr.sv
// ##########################################################
// draw coordinate to framebuffer address, 3 cycle latency
// address is don't-care while clip is high
// ##########################################################

`timescale 1ns/1ns

module bitmap_addr import fb_pkg::*; (
    input  logic     clk_sys,
    input  coord_t   drx,
    input  coord_t   dry,
    output fb_addr_t fb_addr_render,
    output logic     clip
);
    coord_t           x1, y1;   // stage 1
    logic             clip1;
    logic [FB_XW-1:0] x2;       // stage 2
    fb_addr_t         row2;
    logic             clip2;

    // stage 1, register and range test
    always_ff @(posedge clk_sys) begin
        x1    <= drx;
        y1    <= dry;
        clip1 <= (drx < 0) || (drx >= FB_WIDTH)
              || (dry < 0) || (dry >= FB_HEIGHT);
    end

    // stage 2, row base
    always_ff @(posedge clk_sys) begin
        row2  <= fb_addr_t'(y1[FB_YW-1:0] * FB_WIDTH);
        x2    <= x1[FB_XW-1:0];
        clip2 <= clip1;
    end

    // stage 3, add column
    always_ff @(posedge clk_sys) begin
        fb_addr_render <= row2 + fb_addr_t'(x2);
        clip           <= clip2;
    end
endmodule

//--- design/fb_ctrl.sv
// ##########################################################
// per frame: swap banks, clear back bank, draw one square
// sequence takes 512 + size^2 + ~10 cycles, well under a frame
// ##########################################################

`timescale 1ns/1ns

module fb_ctrl import fb_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_sys,
    input  logic     frame,
    input  logic     drawing,
    input  logic     clip,
    input  logic     draw_ack,
    input  fb_addr_t fb_addr_render,
    input  cidx_t    draw_cidx,
    output logic     draw_req,
    output logic     fb_we,
    output logic     front,
    output fb_addr_t fb_addr_write,
    output cidx_t    fb_cidx_write
);
    fb_state_t           state;
    fb_addr_t            clear_addr;
    logic [ADDR_LAT-1:0] we_sr;              // drawing, aligned to address pipe
    cidx_t               cidx_sr [ADDR_LAT]; // colour, same alignment

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state    <= IDLE;
            front    <= 1'b0;
            draw_req <= 1'b0;
        end else begin
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    front <= ~front;  // swap banks
                    state <= CLEAR;
                end
                CLEAR: begin
                    if (clear_addr == fb_addr_t'(FB_PIXELS - 1)) begin
                        draw_req <= 1'b1;  // start renderer handshake
                        state    <= DRAW;
                    end
                end
                DRAW: begin
                    if (draw_ack) begin
                        draw_req <= 1'b0;
                        state    <= DONE;
                    end
                end
                // hold until the last render write has left the pipe
                DONE: if (we_sr == '0) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == INIT) clear_addr <= '0;
        else if (state == CLEAR) clear_addr <= clear_addr + 1'b1;
    end

    // delay drawing by ADDR_LAT so it meets fb_addr_render
    always_ff @(posedge clk_sys) begin
        if (rst_sys) we_sr <= '0;
        else we_sr <= {drawing, we_sr[ADDR_LAT-1:1]};
    end

    always_ff @(posedge clk_sys) begin
        cidx_sr[ADDR_LAT-1] <= draw_cidx;
        for (int i = 0; i < ADDR_LAT - 1; i++) begin
            cidx_sr[i] <= cidx_sr[i+1];
        end
    end

    // write port mux, clear or render
    always_ff @(posedge clk_sys) begin
        if (rst_sys) fb_we <= 1'b0;
        else fb_we <= (state == CLEAR) || (we_sr[0] && !clip);  // drop clipped pixels
    end

    always_ff @(posedge clk_sys) begin
        fb_addr_write <= (state == CLEAR) ? clear_addr : fb_addr_render;
        fb_cidx_write <= (state == CLEAR) ? '0 : cidx_sr[0];  // clear to index 0
    end
endmodule

//--- design/fb_double_bram.sv
// ##########################################################
// two 512 x 4 banks, front selects the displayed one
// writes land in the back bank, read data one cycle later
// ##########################################################

`timescale 1ns/1ns

module fb_double_bram import fb_pkg::*; (
    input  logic     clk_sys,
    input  logic     fb_we,
    input  logic     front,
    input  fb_addr_t fb_addr_write,
    input  fb_addr_t fb_addr_read,
    input  cidx_t    fb_cidx_write,
    output cidx_t    fb_cidx_read
);
    cidx_t bank0 [FB_PIXELS];
    cidx_t bank1 [FB_PIXELS];
    cidx_t rd0, rd1;  // per-bank read registers
    logic  front_q;   // bank select matched to read data

    // front high shows bank1, so draw into bank0
    always_ff @(posedge clk_sys) begin
        if (fb_we && front) bank0[fb_addr_write] <= fb_cidx_write;
        if (fb_we && !front) bank1[fb_addr_write] <= fb_cidx_write;
    end

    always_ff @(posedge clk_sys) begin
        rd0     <= bank0[fb_addr_read];
        rd1     <= bank1[fb_addr_read];
        front_q <= front;
    end

    always_comb fb_cidx_read = front_q ? rd1 : rd0;
endmodule

//--- design/fb_line_scaler.sv
// ##########################################################
// fetches one framebuffer row per pair of screen lines
// scale fixed at 2; pix_cidx lags sx/sy by one cycle
// ##########################################################

`timescale 1ns/1ns

module fb_line_scaler import fb_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_sys,
    input  logic     line,
    input  logic     frame,
    input  coord_t   sx,
    input  coord_t   sy,
    output fb_addr_t fb_addr_read,
    input  cidx_t    fb_cidx_read,
    output cidx_t    pix_cidx
);
    cidx_t            lbuf [FB_WIDTH];  // one framebuffer row
    coord_t           lx, ly;           // position inside painted area
    logic             fetch_line;
    logic             fetching;
    logic [FB_XW-1:0] fetch_cnt;
    logic             wr_en;            // fetching, delayed for bram latency
    logic [FB_XW-1:0] wr_idx;

    always_comb begin
        lx = sx - coord_t'(FB_OFFX);
        ly = sy - coord_t'(FB_OFFY);
        fetch_line = (ly >= 0) && (ly < PAINT_H) && !ly[0];  // first of each pair
    end

    // fetch runs sx 1..32, well ahead of the painted columns
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            fetching     <= 1'b0;
            wr_en        <= 1'b0;
            fb_addr_read <= '0;
        end else begin
            wr_en <= fetching;
            if (frame) begin
                fetching     <= 1'b0;
                fb_addr_read <= '0;  // back to row 0
            end else if (line && fetch_line) begin
                fetching <= 1'b1;
            end else if (fetching) begin
                fb_addr_read <= fb_addr_read + 1'b1;  // ends on next row start
                if (fetch_cnt == FB_XW'(FB_WIDTH - 1)) fetching <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (line) fetch_cnt <= '0;
        else if (fetching) fetch_cnt <= fetch_cnt + 1'b1;
        wr_idx <= fetch_cnt;
    end

    // entry i written by sx 2+i, first read at sx 8+2i
    always_ff @(posedge clk_sys) begin
        if (wr_en) lbuf[wr_idx] <= fb_cidx_read;
        pix_cidx <= lbuf[lx[FB_XW:1]];  // halve x, two pixels per entry
    end
endmodule

//--- design/video_paint.sv
// ##########################################################
// palette lookup and paint-area mask, all outputs registered
// timing delayed one cycle to meet the line buffer read
// ##########################################################

`timescale 1ns/1ns

module video_paint import fb_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  logic       de,
    input  logic       frame,
    input  coord_t     sx,
    input  coord_t     sy,
    input  cidx_t      pix_cidx,
    output coord_t     vid_sx,
    output coord_t     vid_sy,
    output logic       vid_de,
    output logic       vid_frame,
    output logic [7:0] vid_r,
    output logic [7:0] vid_g,
    output logic [7:0] vid_b
);
    coord_t sx_d, sy_d;  // aligned with pix_cidx
    logic   de_d, frame_d;
    logic   paint_area;
    colr_t  paint_colr;

    always_ff @(posedge clk_sys) begin
        sx_d <= sx;
        sy_d <= sy;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            de_d    <= 1'b0;
            frame_d <= 1'b0;
        end else begin
            de_d    <= de;
            frame_d <= frame;
        end
    end

    always_comb begin
        paint_area = (sx_d >= FB_OFFX) && (sx_d < FB_OFFX + PAINT_W)
                  && (sy_d >= FB_OFFY) && (sy_d < FB_OFFY + PAINT_H);
        paint_colr = (de_d && paint_area) ? PALETTE[pix_cidx] : '0;  // black border
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            vid_de    <= 1'b0;
            vid_frame <= 1'b0;
        end else begin
            vid_de    <= de_d;
            vid_frame <= frame_d;
        end
    end

    // 4 to 8 bits by repeating the channel
    always_ff @(posedge clk_sys) begin
        vid_sx <= sx_d;
        vid_sy <= sy_d;
        vid_r  <= {2{paint_colr[COLRW-1 -: CHANW]}};
        vid_g  <= {2{paint_colr[2*CHANW-1 -: CHANW]}};
        vid_b  <= {2{paint_colr[CHANW-1:0]}};
    end
endmodule

//--- design/dbuf_shapes_top.sv
// ##########################################################
// double-buffered square demo, single clock domain
// video outputs lag the scan counters by two cycles
// ##########################################################

`timescale 1ns/1ns

module dbuf_shapes_top import fb_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  coord_t     shape_x,
    input  coord_t     shape_y,
    input  coord_t     shape_size,
    input  cidx_t      shape_cidx,
    output coord_t     vid_sx,
    output coord_t     vid_sy,
    output logic       vid_de,
    output logic       vid_frame,
    output logic [7:0] vid_r,
    output logic [7:0] vid_g,
    output logic [7:0] vid_b
);
    coord_t   sx, sy;              // scan position
    logic     de, line, frame;
    logic     draw_req, draw_ack;  // four-phase handshake
    logic     drawing, clip;
    coord_t   drx, dry;
    cidx_t    draw_cidx;
    fb_addr_t fb_addr_render, fb_addr_write, fb_addr_read;
    cidx_t    fb_cidx_write, fb_cidx_read;
    logic     fb_we, front;
    cidx_t    pix_cidx;

    display_timing display_timing_inst (
        .clk_sys, .rst_sys, .sx, .sy, .de, .line, .frame
    );

    render_square render_square_inst (
        .clk_sys, .rst_sys, .draw_req,
        .shape_x, .shape_y, .shape_size, .shape_cidx,
        .drx, .dry, .draw_cidx, .drawing, .draw_ack
    );

    bitmap_addr bitmap_addr_inst (
        .clk_sys, .drx, .dry, .fb_addr_render, .clip
    );

    fb_ctrl fb_ctrl_inst (
        .clk_sys, .rst_sys, .frame, .drawing, .clip, .draw_ack,
        .fb_addr_render, .draw_cidx,
        .draw_req, .fb_we, .front, .fb_addr_write, .fb_cidx_write
    );

    fb_double_bram fb_double_bram_inst (
        .clk_sys, .fb_we, .front,
        .fb_addr_write, .fb_addr_read, .fb_cidx_write, .fb_cidx_read
    );

    fb_line_scaler fb_line_scaler_inst (
        .clk_sys, .rst_sys, .line, .frame, .sx, .sy,
        .fb_addr_read, .fb_cidx_read, .pix_cidx
    );

    video_paint video_paint_inst (
        .clk_sys, .rst_sys, .de, .frame, .sx, .sy, .pix_cidx,
        .vid_sx, .vid_sy, .vid_de, .vid_frame, .vid_r, .vid_g, .vid_b
    );
endmodule

//--- bench/fb_ctrl_props.sv
// ##########################################################
// renderer handshake and frame sequence checks on fb_ctrl
// bound into every fb_ctrl, all checks idle during reset
// ##########################################################

`timescale 1ns/1ns

module fb_ctrl_props import fb_pkg::*; (
    input logic      clk_sys,
    input logic      rst_sys,
    input logic      draw_req,
    input logic      draw_ack,
    input logic      front,
    input logic      fb_we,
    input fb_state_t state
);
    int fail_count = 0;  // failed assertions so far

    ack_needs_req: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(draw_ack) |-> draw_req)
        else begin
            $error("draw_ack rose while draw_req was low");
            fail_count++;
        end

    // four-phase, req only falls once ack has been seen
    req_waits_ack: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $fell(draw_req) |-> $past(draw_ack))
        else begin
            $error("draw_req fell before draw_ack");
            fail_count++;
        end

    front_in_init: assert property (@(posedge clk_sys) disable iff (rst_sys)
        (front != $past(front)) |-> ($past(state) == INIT))
        else begin
            $error("front toggled outside INIT");
            fail_count++;
        end

    idle_no_write: assert property (@(posedge clk_sys) disable iff (rst_sys)
        (state == IDLE) |-> !fb_we)
        else begin
            $error("fb_we high in IDLE");
            fail_count++;
        end
endmodule

bind fb_ctrl fb_ctrl_props fb_ctrl_props_inst (
    .clk_sys, .rst_sys, .draw_req, .draw_ack, .front, .fb_we, .state
);

//--- bench/dbuf_shapes_tb.sv
// ##########################################################
// one table row per frame and every pixel of the next frame checked
// runs about 9 frames of 4800 cycles at a 4 ns clock
// ##########################################################

`timescale 1ns/1ns

module dbuf_shapes_tb
    import fb_pkg::*;
();
    localparam int NROWS         = 8;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;  // 4800
    localparam int FRAME_TIMEOUT = 10000;
    localparam int RESET_CYCLES  = 3;

    logic       clk_sys;
    logic       rst_sys;
    coord_t     shape_x, shape_y, shape_size;
    cidx_t      shape_cidx;
    coord_t     vid_sx, vid_sy;
    logic       vid_de, vid_frame;
    logic [7:0] vid_r, vid_g, vid_b;

    // shape table with the expected square colour last
    int    tab_x    [NROWS];
    int    tab_y    [NROWS];
    int    tab_size [NROWS];
    int    tab_cidx [NROWS];
    colr_t tab_colr [NROWS];

    int error_count;
    int check_count;
    int cycle;      // free-running clock count
    bit timed_out;

    dbuf_shapes_top dbuf_shapes_top_inst (
        .clk_sys(clk_sys), .rst_sys(rst_sys),
        .shape_x(shape_x), .shape_y(shape_y),
        .shape_size(shape_size), .shape_cidx(shape_cidx),
        .vid_sx(vid_sx), .vid_sy(vid_sy), .vid_de(vid_de), .vid_frame(vid_frame),
        .vid_r(vid_r), .vid_g(vid_g), .vid_b(vid_b)
    );

    always #2 clk_sys = ~clk_sys;  // 4 ns period

    always @(posedge clk_sys) cycle <= cycle + 1;

    task automatic set_row(input int i, input int x, input int y, input int size,
                           input int cidx, input colr_t colr);
        tab_x[i]    = x;
        tab_y[i]    = y;
        tab_size[i] = size;
        tab_cidx[i] = cidx;
        tab_colr[i] = colr;
    endtask

    task automatic load_table();
        set_row(0,  4,  3,  5,  1, 12'hF00);  // plain square
        set_row(1, 10,  6,  8,  2, 12'h0F0);
        set_row(2, 28,  2,  8,  3, 12'h00F);  // crosses right edge without wrapping
        set_row(3,  5, 12,  7,  4, 12'hFF0);  // crosses bottom edge
        set_row(4, -3, -2,  6,  5, 12'h0FF);  // negative corner
        set_row(5, -3, -2,  6,  9, 12'hF80);  // same place with a new colour
        set_row(6, 20,  0, 16, 12, 12'hF08);  // full height and clipped on the right
        set_row(7, 31, 15,  1, 14, 12'h0F8);  // last pixel only
    endtask

    task automatic apply_row(input int i);
        shape_x    <= coord_t'(tab_x[i]);
        shape_y    <= coord_t'(tab_y[i]);
        shape_size <= coord_t'(tab_size[i]);
        shape_cidx <= cidx_t'(tab_cidx[i]);
    endtask

    // screen pixel to colour for the square of row r
    function automatic colr_t expected_colr(input int r, input int px, input int py);
        int fx, fy;
        if (px < FB_OFFX || px >= FB_OFFX + FB_WIDTH * FB_SCALE
            || py < FB_OFFY || py >= FB_OFFY + FB_HEIGHT * FB_SCALE) begin
            return 12'h000;  // black border
        end
        fx = (px - FB_OFFX) / FB_SCALE;
        fy = (py - FB_OFFY) / FB_SCALE;
        if (fx >= tab_x[r] && fx < tab_x[r] + tab_size[r]
            && fy >= tab_y[r] && fy < tab_y[r] + tab_size[r]) begin
            return tab_colr[r];
        end
        return PALETTE[0];  // cleared background
    endfunction

    // n counts cycles from the vid_frame cycle
    task automatic check_pixel(input int r, input int n);
        int         px, py;
        logic       exp_de;
        colr_t      colr;
        logic [7:0] exp_r, exp_g, exp_b;
        px     = n % H_TOTAL;
        py     = n / H_TOTAL;
        exp_de = (px < H_ACTIVE) && (py < V_ACTIVE);
        colr   = exp_de ? expected_colr(r, px, py) : 12'h000;
        exp_r  = {2{colr[11:8]}};
        exp_g  = {2{colr[7:4]}};
        exp_b  = {2{colr[3:0]}};
        check_count++;
        if (vid_sx !== coord_t'(px) || vid_sy !== coord_t'(py)) begin
            $display("[ERROR] vid_sx/vid_sy: expected %h/%h, got %h/%h",
                     coord_t'(px), coord_t'(py), vid_sx, vid_sy);
            error_count++;
        end
        if (vid_de !== exp_de) begin
            $display("[ERROR] vid_de at x=%0d y=%0d: expected %h, got %h",
                     px, py, exp_de, vid_de);
            error_count++;
        end
        if (n != 0 && vid_frame !== 1'b0) begin
            $display("[ERROR] vid_frame at x=%0d y=%0d: expected 0, got %h",
                     px, py, vid_frame);
            error_count++;
        end
        if (vid_r !== exp_r) begin
            $display("[ERROR] vid_r at x=%0d y=%0d: expected %h, got %h", px, py, exp_r, vid_r);
            error_count++;
        end
        if (vid_g !== exp_g) begin
            $display("[ERROR] vid_g at x=%0d y=%0d: expected %h, got %h", px, py, exp_g, vid_g);
            error_count++;
        end
        if (vid_b !== exp_b) begin
            $display("[ERROR] vid_b at x=%0d y=%0d: expected %h, got %h", px, py, exp_b, vid_b);
            error_count++;
        end
    endtask

    // ends on the negedge where vid_frame is high
    task automatic wait_frame(input bit quiet, output bit found);
        int n;
        found = 1'b0;
        n     = 0;
        while (!found && n < FRAME_TIMEOUT) begin
            @(negedge clk_sys);
            n++;
            if (vid_frame === 1'b1) begin
                found = 1'b1;
            end else if (quiet && vid_de !== 1'b0) begin
                $display("[ERROR] vid_de before the first vid_frame: expected 0, got %h",
                         vid_de);
                error_count++;
            end
        end
    endtask

    initial begin
        int k;
        int n;
        int last_frame;
        int prop_fails;
        bit found;
        clk_sys     = 1'b0;
        rst_sys     = 1'b1;
        shape_x     = '0;
        shape_y     = '0;
        shape_size  = coord_t'(1);
        shape_cidx  = '0;
        error_count = 0;
        check_count = 0;
        cycle       = 0;
        timed_out   = 1'b0;
        last_frame  = 0;
        load_table();

        // video outputs stay quiet through reset
        for (k = 0; k < RESET_CYCLES; k++) begin
            @(posedge clk_sys);
            if (k == RESET_CYCLES - 1) rst_sys <= 1'b0;
            @(negedge clk_sys);
            if (vid_de !== 1'b0 || vid_frame !== 1'b0) begin
                $display("[ERROR] vid_de/vid_frame during reset: expected 0/0, got %h/%h",
                         vid_de, vid_frame);
                error_count++;
            end
        end

        // frame k shows row k-1 while row k is being drawn
        for (k = 0; k <= NROWS && !timed_out; k++) begin
            wait_frame(k == 0, found);
            if (!found) begin
                $display("no vid_frame within %0d cycles", FRAME_TIMEOUT);
                timed_out = 1'b1;
            end else begin
                if (k > 0 && cycle - last_frame != FRAME_CYCLES) begin
                    $display("vid_frame period was %0d cycles, not %0d",
                             cycle - last_frame, FRAME_CYCLES);
                    error_count++;
                end
                last_frame = cycle;
                if (k > 0) check_pixel(k - 1, 0);  // top-left pixel on the vid_frame cycle
                @(posedge clk_sys);
                if (k < NROWS) apply_row(k);
                if (k > 0) begin
                    for (n = 1; n < FRAME_CYCLES; n++) begin
                        @(negedge clk_sys);
                        check_pixel(k - 1, n);
                    end
                end
            end
        end

        prop_fails = dbuf_shapes_top_inst.fb_ctrl_inst.fb_ctrl_props_inst.fail_count;
        $display("pixel checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, error_count, prop_fails, timed_out);
        if (error_count == 0 && prop_fails == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end
endmodule

//--- dbuf_shapes.f
design/fb_pkg.sv
design/display_timing.sv
design/render_square.sv
design/bitmap_addr.sv
design/fb_ctrl.sv
design/fb_double_bram.sv
design/fb_line_scaler.sv
design/video_paint.sv
design/dbuf_shapes_top.sv
bench/fb_ctrl_props.sv
bench/dbuf_shapes_tb.sv
